//--- design/tage_params.svh
`ifndef TAGE_PARAMS_SVH
`define TAGE_PARAMS_SVH

// entries in the bimodal base table
`define TAGE_BASE_SIZE 256

// entries per tagged table, sets the hash width
`define TAGE_TABLE_SIZE 64

// tag bits stored per tagged entry
`define TAGE_TAG_SIZE 8

// base stage plus the tagged stages
`define TAGE_NUM_STAGES 3

// accepted updates between two aging sweeps
`define TAGE_AGE_PERIOD 32

`endif

//--- design/BranchPkg.sv
`include "tage_params.svh"

package BranchPkg;

    // global history as handed in by the caller
    typedef logic [15:0] BHist_t;

    // branch address without the halfword bit
    typedef logic [30:0] BranchAddr_t;

    // number of the stage that provided a prediction
    typedef logic [$clog2(`TAGE_NUM_STAGES)-1:0] StageId_t;

    // one bit per stage, base stage in bit 0
    typedef logic [`TAGE_NUM_STAGES-1:0] StageVec_t;

endpackage

//--- design/TagePkg.sv
`include "tage_params.svh"

package TagePkg;

    // row select of a tagged table
    typedef logic [$clog2(`TAGE_TABLE_SIZE)-1:0] TageIndex_t;

    // partial tag kept per entry
    typedef logic [`TAGE_TAG_SIZE-1:0] TageTag_t;

    // one tagged entry, 12 bits wide
    typedef struct packed {
        logic valid;
        TageTag_t tag;
        logic [1:0] counter;
        logic useful;
    } TageEntry_t;

    // maintenance sweep modes
    typedef enum logic [1:0] {
        StIdle,
        StClear,
        StAge
    } SweepState_t;

endpackage

//--- design/TableSweepIf.sv
`include "tage_params.svh"

interface TableSweepIf;

    // a sweep is running, tables serve sweepIndex this cycle
    logic sweepActive;
    logic [$clog2(`TAGE_TABLE_SIZE)-1:0] sweepIndex;
    // wipe the row
    logic sweepClear;
    // drop the useful bit of the row
    logic sweepAge;

    modport ctrl (
        output sweepActive, sweepIndex, sweepClear, sweepAge
    );

    modport tbl (
        input sweepActive, sweepIndex, sweepClear, sweepAge
    );

endinterface

//--- design/BranchPredictionTable.sv
`include "tage_params.svh"

module BranchPredictionTable (
    input logic clk,
    input logic rst,

    input logic [$clog2(`TAGE_BASE_SIZE)-1:0] readAddr,
    output logic taken,

    input logic writeEn,
    input logic [$clog2(`TAGE_BASE_SIZE)-1:0] writeAddr,
    input logic writeTaken,

    TableSweepIf.tbl sweep
);

    // base rows cleared per sweep step
    localparam int Spread = `TAGE_BASE_SIZE / `TAGE_TABLE_SIZE;
    localparam int SpreadBits = $clog2(Spread);

    logic [1:0] counters [`TAGE_BASE_SIZE];
    logic [1:0] wrCounter;

    assign wrCounter = counters[writeAddr];

    always_ff @(posedge clk) begin
        if (sweep.sweepActive && sweep.sweepClear) begin
            // sweep index picks the upper bits, four rows at once
            for (int i = 0; i < Spread; i++) begin
                counters[{sweep.sweepIndex, SpreadBits'(i)}] <= 2'b01;
            end
        end else if (writeEn) begin
            if (writeTaken) begin
                counters[writeAddr] <= (wrCounter == 2'b11) ? wrCounter : wrCounter + 2'b01;
            end else begin
                counters[writeAddr] <= (wrCounter == 2'b00) ? wrCounter : wrCounter - 2'b01;
            end
        end
    end

    // msb of the counter is the direction
    always_ff @(posedge clk) begin
        if (rst) begin
            taken <= 1'b0;
        end else begin
            taken <= counters[readAddr][1];
        end
    end

endmodule

//--- design/TageTable.sv
`include "tage_params.svh"

module TageTable import TagePkg::*; (
    input logic clk,
    input logic rst,

    input TageIndex_t readIndex,
    input TageTag_t readTag,
    output logic readValid,
    output logic readTaken,

    input TageIndex_t writeIndex,
    input TageTag_t writeTag,
    input logic writeTaken,
    input logic writeValid,
    input logic writeNew,
    input logic writeUseful,
    input logic writeUpdate,
    output logic writeAlloc,
    input logic anyAlloc,

    TableSweepIf.tbl sweep
);

    TageEntry_t entries [`TAGE_TABLE_SIZE];

    TageEntry_t rdEntry;
    TageEntry_t wrEntry;
    logic wrHit;
    logic [1:0] nextCounter;

    assign rdEntry = entries[readIndex];
    assign wrEntry = entries[writeIndex];

    // provider entry may have been replaced since the prediction
    assign wrHit = wrEntry.valid && (wrEntry.tag == writeTag);

    // free row: never written or not proven useful
    assign writeAlloc = writeValid && writeNew && (!wrEntry.valid || !wrEntry.useful);

    always_comb begin
        nextCounter = wrEntry.counter;
        if (writeTaken) begin
            if (wrEntry.counter != 2'b11) begin
                nextCounter = wrEntry.counter + 2'b01;
            end
        end else begin
            if (wrEntry.counter != 2'b00) begin
                nextCounter = wrEntry.counter - 2'b01;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sweep.sweepActive) begin
            if (sweep.sweepClear) begin
                entries[sweep.sweepIndex] <= '0;
            end else if (sweep.sweepAge) begin
                entries[sweep.sweepIndex].useful <= 1'b0;
            end
        end else if (writeValid) begin
            if (writeUpdate && wrHit) begin
                entries[writeIndex].counter <= nextCounter;
                entries[writeIndex].useful <= writeUseful;
            end else if (writeAlloc && anyAlloc) begin
                // install weak in the resolved direction
                entries[writeIndex] <= '{
                    valid: 1'b1,
                    tag: writeTag,
                    counter: writeTaken ? 2'b10 : 2'b01,
                    useful: 1'b0
                };
            end
        end
    end

    // hit needs both a live entry and a matching tag
    always_ff @(posedge clk) begin
        if (rst) begin
            readValid <= 1'b0;
        end else begin
            readValid <= rdEntry.valid && (rdEntry.tag == readTag);
        end
    end

    always_ff @(posedge clk) begin
        readTaken <= rdEntry.counter[1];
    end

endmodule

//--- design/TagePredictor.sv
`include "tage_params.svh"

module TagePredictor import BranchPkg::*, TagePkg::*; (
    input logic clk,
    input logic rst,

    input logic predValid,
    input BranchAddr_t predAddr,
    input BHist_t predHistory,
    output logic predOutValid,
    output logic predTaken,
    output StageId_t predTageId,
    output StageVec_t predUseful,

    input logic writeValid,
    input BranchAddr_t writeAddr,
    input BHist_t writeHistory,
    input StageId_t writeTageId,
    input logic writeTaken,
    input StageVec_t writeUseful,
    input logic writePred,

    TableSweepIf.tbl sweep,
    input logic busy
);

    localparam int NumStages = `TAGE_NUM_STAGES;
    localparam int HashSize = $clog2(`TAGE_TABLE_SIZE);
    localparam int TagSize = `TAGE_TAG_SIZE;
    localparam int BaseBits = $clog2(`TAGE_BASE_SIZE);

    // stage s folds 2^(s-1) history chunks into index and tag
    function automatic TageIndex_t stageIndex(input BranchAddr_t addr, input BHist_t hist,
                                              input int stage);
        TageIndex_t idx;
        idx = addr[HashSize-1:0] ^ addr[2*HashSize-1:HashSize];
        for (int j = 0; j < (1 << (stage - 1)); j++) begin
            idx = idx ^ hist[HashSize*j +: HashSize];
        end
        return idx;
    endfunction

    function automatic TageTag_t stageTag(input BranchAddr_t addr, input BHist_t hist,
                                          input int stage);
        TageTag_t tag;
        tag = addr[TagSize-1:0];
        for (int j = 0; j < (1 << (stage - 1)); j++) begin
            tag = tag ^ hist[TagSize*j +: TagSize];
        end
        return tag;
    endfunction

    wire StageVec_t hitVec;
    wire StageVec_t takenVec;
    wire StageVec_t allocVec;

    logic wrAccepted;
    logic mispredict;

    assign wrAccepted = writeValid && !busy;
    assign mispredict = writeTaken != writePred;

    // base stage always answers
    assign hitVec[0] = 1'b1;
    assign allocVec[0] = 1'b0;

    BranchPredictionTable basePredictor (
        .clk(clk),
        .rst(rst),
        .readAddr(predAddr[BaseBits-1:0]),
        .taken(takenVec[0]),
        .writeEn(wrAccepted),
        .writeAddr(writeAddr[BaseBits-1:0]),
        .writeTaken(writeTaken),
        .sweep(sweep)
    );

    for (genvar s = 1; s < NumStages; s++) begin : gStage
        logic isProvider;
        logic wantNew;
        logic setUseful;

        assign isProvider = StageId_t'(s) == writeTageId;
        // only above the provider and only the lowest free stage
        assign wantNew = mispredict && !allocVec[s-1] && (StageId_t'(s) > writeTageId);
        // useful when this stage alone got it right
        assign setUseful = (writeUseful[s] == writeTaken) && (writeUseful[s] != writeUseful[s-1]);

        TageTable tageTable (
            .clk(clk),
            .rst(rst),
            .readIndex(stageIndex(predAddr, predHistory, s)),
            .readTag(stageTag(predAddr, predHistory, s)),
            .readValid(hitVec[s]),
            .readTaken(takenVec[s]),
            .writeIndex(stageIndex(writeAddr, writeHistory, s)),
            .writeTag(stageTag(writeAddr, writeHistory, s)),
            .writeTaken(writeTaken),
            .writeValid(wrAccepted),
            .writeNew(wantNew),
            .writeUseful(setUseful),
            .writeUpdate(isProvider),
            .writeAlloc(allocVec[s]),
            .anyAlloc(|allocVec),
            .sweep(sweep)
        );
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            predOutValid <= 1'b0;
        end else begin
            predOutValid <= predValid && !busy;
        end
    end

    // longest hitting stage wins, useful bits record the running choice
    always_comb begin
        predTaken = takenVec[0];
        predTageId = '0;
        for (int i = 0; i < NumStages; i++) begin
            if (hitVec[i]) begin
                predTaken = takenVec[i];
                predTageId = StageId_t'(i);
            end
            predUseful[i] = predTaken;
        end
    end

endmodule

//--- design/AgingTimer.sv
`include "tage_params.svh"

module AgingTimer (
    input logic clk,
    input logic rst,
    input logic updateAccepted,
    output logic ageRequest
);

    localparam int CountBits = $clog2(`TAGE_AGE_PERIOD);

    logic [CountBits-1:0] updateCount;

    always_ff @(posedge clk) begin
        if (rst) begin
            updateCount <= '0;
            ageRequest <= 1'b0;
        end else begin
            ageRequest <= 1'b0;
            if (updateAccepted) begin
                updateCount <= updateCount + 1'b1;
                // last update of the period, request a sweep
                if (updateCount == CountBits'(`TAGE_AGE_PERIOD - 1)) begin
                    ageRequest <= 1'b1;
                end
            end
        end
    end

endmodule

//--- design/TageMaintenance.sv
`include "tage_params.svh"

module TageMaintenance import TagePkg::*; (
    input logic clk,
    input logic rst,
    input logic ageRequest,
    TableSweepIf.ctrl sweep,
    output logic busy
);

    localparam int IndexBits = $clog2(`TAGE_TABLE_SIZE);

    SweepState_t state;
    logic [IndexBits-1:0] index;

    always_ff @(posedge clk) begin
        if (rst) begin
            // tables hold garbage until the first clear pass
            state <= StClear;
            index <= '0;
        end else begin
            case (state)
                StIdle: begin
                    index <= '0;
                    if (ageRequest) begin
                        state <= StAge;
                    end
                end
                StClear, StAge: begin
                    index <= index + 1'b1;
                    if (index == '1) begin
                        state <= StIdle;
                    end
                end
                default: begin
                    state <= StIdle;
                    index <= '0;
                end
            endcase
        end
    end

    assign busy = state != StIdle;

    assign sweep.sweepActive = state != StIdle;
    assign sweep.sweepIndex = index;
    assign sweep.sweepClear = state == StClear;
    assign sweep.sweepAge = state == StAge;

endmodule

//--- design/BranchPredictorUnit.sv
module BranchPredictorUnit import BranchPkg::*; (
    input logic clk,
    input logic rst,

    input logic predValid,
    input BranchAddr_t predAddr,
    input BHist_t predHistory,
    output logic predOutValid,
    output logic predTaken,
    output StageId_t predTageId,
    output StageVec_t predUseful,

    input logic writeValid,
    input BranchAddr_t writeAddr,
    input BHist_t writeHistory,
    input StageId_t writeTageId,
    input logic writeTaken,
    input StageVec_t writeUseful,
    input logic writePred,

    output logic busy
);

    logic ageRequest;

    TableSweepIf sweepIf ();

    TagePredictor predictor (
        .clk(clk),
        .rst(rst),
        .predValid(predValid),
        .predAddr(predAddr),
        .predHistory(predHistory),
        .predOutValid(predOutValid),
        .predTaken(predTaken),
        .predTageId(predTageId),
        .predUseful(predUseful),
        .writeValid(writeValid),
        .writeAddr(writeAddr),
        .writeHistory(writeHistory),
        .writeTageId(writeTageId),
        .writeTaken(writeTaken),
        .writeUseful(writeUseful),
        .writePred(writePred),
        .sweep(sweepIf),
        .busy(busy)
    );

    // only updates that reach the tables count toward aging
    AgingTimer agingTimer (
        .clk(clk),
        .rst(rst),
        .updateAccepted(writeValid && !busy),
        .ageRequest(ageRequest)
    );

    TageMaintenance maintenance (
        .clk(clk),
        .rst(rst),
        .ageRequest(ageRequest),
        .sweep(sweepIf),
        .busy(busy)
    );

endmodule

//--- sim/tb_BranchPredictorUnit.sv
module tb_BranchPredictorUnit import BranchPkg::*; ();

    localparam int MaxOps = 128;

    logic clk;
    logic rst;
    logic predValid;
    BranchAddr_t predAddr;
    BHist_t predHistory;
    logic predOutValid;
    logic predTaken;
    StageId_t predTageId;
    StageVec_t predUseful;
    logic writeValid;
    BranchAddr_t writeAddr;
    BHist_t writeHistory;
    StageId_t writeTageId;
    logic writeTaken;
    StageVec_t writeUseful;
    logic writePred;
    logic busy;

    // one trace operation per entry, fields as listed in the trace header
    logic [7:0] opKind [MaxOps];
    logic [63:0] opName [MaxOps];
    logic [31:0] opAddr [MaxOps];
    logic [15:0] opHist [MaxOps];
    logic [3:0] opField [MaxOps][4];

    int numOps;
    int cycleCount;
    int cycleLimit;
    int errCount;

    BranchPredictorUnit BranchPredictorUnit_i (
        .clk(clk),
        .rst(rst),
        .predValid(predValid),
        .predAddr(predAddr),
        .predHistory(predHistory),
        .predOutValid(predOutValid),
        .predTaken(predTaken),
        .predTageId(predTageId),
        .predUseful(predUseful),
        .writeValid(writeValid),
        .writeAddr(writeAddr),
        .writeHistory(writeHistory),
        .writeTageId(writeTageId),
        .writeTaken(writeTaken),
        .writeUseful(writeUseful),
        .writePred(writePred),
        .busy(busy)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycleCount);
            failRun();
        end
    end

    task automatic failRun();
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check(input logic [63:0] testName, input logic [8*10-1:0] what,
                         input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            errCount++;
            $display("FAILED %0s %0s: expected %0h, actual %0h", testName, what,
                     expected, actual);
            failRun();
        end
    endtask

    // strobes are dropped during a sweep
    task automatic waitIdle();
        while (busy) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic predictAndCheck(input int k);
        waitIdle();
        predValid = 1'b1;
        predAddr = opAddr[k][30:0];
        predHistory = opHist[k];
        @(posedge clk);
        #2;
        predValid = 1'b0;
        check(opName[k], "outValid", 1, predOutValid);
        check(opName[k], "taken", opField[k][0], predTaken);
        check(opName[k], "tageId", opField[k][1], predTageId);
        check(opName[k], "useful", opField[k][2], predUseful);
    endtask

    task automatic driveUpdate(input int k);
        writeAddr = opAddr[k][30:0];
        writeHistory = opHist[k];
        writeTageId = opField[k][0][1:0];
        writeTaken = opField[k][1][0];
        writeUseful = opField[k][2][2:0];
        writePred = opField[k][3][0];
    endtask

    task automatic applyUpdate(input int k);
        waitIdle();
        driveUpdate(k);
        writeValid = 1'b1;
        @(posedge clk);
        #2;
        writeValid = 1'b0;
    endtask

    // both strobes at once while the aging sweep runs
    task automatic strobeWhileBusy(input int k);
        int waited;
        waited = 0;
        while (!busy && waited < 4) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!busy) begin
            $display("busy did not rise for the aging sweep before test %0s", opName[k]);
            failRun();
        end
        driveUpdate(k);
        predAddr = opAddr[k][30:0];
        predHistory = opHist[k];
        predValid = 1'b1;
        writeValid = 1'b1;
        @(posedge clk);
        #2;
        predValid = 1'b0;
        writeValid = 1'b0;
        check(opName[k], "outValid", 0, predOutValid);
    endtask

    task automatic loadTrace();
        int fd;
        int code;
        logic done;
        logic [63:0] token;
        logic [63:0] name;
        logic [31:0] addr;
        logic [15:0] hist;
        logic [3:0] fields [4];
        logic [8*160-1:0] rest;
        fd = $fopen("sim/tage_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file sim/tage_trace.txt");
            failRun();
        end
        numOps = 0;
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, "%s", token);
            if (code != 1) begin
                done = 1'b1;
            end else if (token == "#") begin
                // comment line, drop the rest of it
                code = $fgets(rest, fd);
            end else begin
                code = $fscanf(fd, "%s %h %h %h %h %h %h", name, addr, hist,
                               fields[0], fields[1], fields[2], fields[3]);
                if (code != 7 || numOps >= MaxOps) begin
                    $display("trace entry %0d is malformed or the trace is too long",
                             numOps + 1);
                    failRun();
                end
                opKind[numOps] = token[7:0];
                opName[numOps] = name;
                opAddr[numOps] = addr;
                opHist[numOps] = hist;
                for (int i = 0; i < 4; i++) begin
                    opField[numOps][i] = fields[i];
                end
                numOps++;
            end
        end
        $fclose(fd);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        predValid = 1'b0;
        predAddr = '0;
        predHistory = '0;
        writeValid = 1'b0;
        writeAddr = '0;
        writeHistory = '0;
        writeTageId = '0;
        writeTaken = 1'b0;
        writeUseful = '0;
        writePred = 1'b0;
        cycleCount = 0;
        cycleLimit = 0;
        errCount = 0;
        loadTrace();
        // worst case per operation is a full sweep plus the strobe
        cycleLimit = numOps * 70 + 100;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int k = 0; k < numOps; k++) begin
            case (opKind[k])
                "P": predictAndCheck(k);
                "W": applyUpdate(k);
                "B": strobeWhileBusy(k);
                default: begin
                    $display("unknown operation in trace entry %0d", k + 1);
                    failRun();
                end
            endcase
        end
        if (errCount == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            failRun();
        end
    end

endmodule

//--- sim/tage_trace.txt
# op name addr hist, then P: taken tageId useful 0, W and B: tageId taken useful pred
# all values hex, B strobes both ports while the aging sweep holds busy
P t1a 12345 abcd 0 0 0 0
P t1b 0 0 0 0 0 0
W t2a 40 0 0 0 0 0
P t2b 40 0 0 0 0 0
W t2c 40 0 0 1 7 1
P t2d 40 0 0 0 0 0
W t2e 40 0 0 1 7 1
P t2f 40 0 1 0 7 0
W t2g 40 0 0 1 7 1
W t2h 40 0 0 1 7 1
P t2i 40 0 1 0 7 0
W t2j 40 0 0 0 0 0
W t2k 40 0 0 0 0 0
P t2l 40 0 0 0 0 0
W t2m 40 0 0 0 0 0
P t2n 40 0 0 0 0 0
W t3a c3 1205 0 1 7 1
W t3b c3 1205 0 1 7 1
P t3c c3 1205 1 0 7 0
W t3d c3 1205 0 0 7 1
P t3e c3 1205 0 1 1 0
P t3f c3 0 1 0 7 0
W t4a c3 1205 1 0 1 0
P t4b c3 1205 0 1 0 0
P t4c c3 3045 0 0 0 0
W t4d c3 3045 0 1 0 0
P t4e c3 3045 1 2 7 0
P t4f c3 1205 0 1 1 0
W t5fill 200 0 0 1 7 1
W t5fill 200 0 0 1 7 1
W t5fill 200 0 0 1 7 1
W t5fill 200 0 0 1 7 1
W t5fill 200 0 0 1 7 1
W t5fill 200 0 0 1 7 1
W t5fill 200 0 0 1 7 1
W t5fill 200 0 0 1 7 1
W t5fill 200 0 0 1 7 1
W t5fill 200 0 0 1 7 1
W t5fill 200 0 0 1 7 1
W t5fill 200 0 0 1 7 1
W t5fill 200 0 0 1 7 1
W t5fill 200 0 0 1 7 1
W t5fill 200 0 0 1 7 1
W t5fill 200 0 0 1 7 1
W t5fill 200 0 0 1 7 1
W t5fill 200 0 0 1 7 1
W t5fill 200 0 0 1 7 1
B t6a c3 1205 1 1 0 0
P t6b c3 1205 0 1 1 0
P t5b c3 3045 1 2 7 0
P t5c c3 85 1 0 7 0
W t5d c3 85 0 0 7 1
P t5e c3 85 0 1 0 0
P t5f c3 1205 0 0 0 0

//--- compile.f
+incdir+design
design/BranchPkg.sv
design/TagePkg.sv
design/TableSweepIf.sv
design/BranchPredictionTable.sv
design/TageTable.sv
design/TagePredictor.sv
design/AgingTimer.sv
design/TageMaintenance.sv
design/BranchPredictorUnit.sv
sim/tb_BranchPredictorUnit.sv

//--- Bender.yml
package:
  name: branch_predictor_unit

sources:
  - include_dirs:
      - design
    files:
      - design/BranchPkg.sv
      - design/TagePkg.sv
      - design/TableSweepIf.sv
      - design/BranchPredictionTable.sv
      - design/TageTable.sv
      - design/TagePredictor.sv
      - design/AgingTimer.sv
      - design/TageMaintenance.sv
      - design/BranchPredictorUnit.sv
  - target: simulation
    files:
      - sim/tb_BranchPredictorUnit.sv
